// File: common/accel_pkg.sv
`default_nettype none

package accel_pkg;

  // ======================================================================
  // Sizes
  // ======================================================================
  localparam int IO_DATA_WIDTH        = 32;
  localparam int IO_STRB_WIDTH        = 4;
  localparam int IO_ADDR_WIDTH        = 12;
  localparam int ACCEL_COUNT          = 4;
  localparam int ACCEL_SEL_WIDTH      = 2;
  localparam int PMEM_WORDS           = 256;
  localparam int PMEM_WORD_ADDR_WIDTH = 8;
  localparam int PMEM_ADDR_WIDTH      = 10;  // Byte address.
  localparam int LEN_WIDTH            = 16;

  // ======================================================================
  // Per-engine register map
  // ======================================================================
  localparam logic [3:0] REG_CTRL    = 4'd0;
  localparam logic [3:0] REG_LEN     = 4'd4;
  localparam logic [3:0] REG_ADDR    = 4'd8;
  localparam logic [3:0] REG_PATTERN = 4'd12;

  // Search command, pattern byte 0 is matched first.
  typedef struct packed {
    logic [PMEM_ADDR_WIDTH-1:0] addr;
    logic [LEN_WIDTH-1:0]       len;
    logic [31:0]                pattern;
  } cmd_t;

  typedef struct packed {
    logic busy;
    logic done;
    logic match;
  } status_t;

  typedef struct packed {
    logic [PMEM_WORD_ADDR_WIDTH-1:0] addr;
  } mem_req_t;

  typedef struct packed {
    logic        valid;
    logic [31:0] data;
  } mem_rsp_t;

endpackage

`default_nettype wire

// File: source/accel_regs.sv
`default_nettype none

module accel_regs (
  input  logic                                   clk,
  input  logic                                   rst,

  input  logic                                   io_en,
  input  logic                                   io_wen,
  input  logic [accel_pkg::IO_STRB_WIDTH-1:0]    io_strb,
  input  logic [accel_pkg::IO_ADDR_WIDTH-1:0]    io_addr,
  input  logic [accel_pkg::IO_DATA_WIDTH-1:0]    io_wr_data,
  output logic [accel_pkg::IO_DATA_WIDTH-1:0]    io_rd_data,
  output logic                                   io_rd_valid,

  output accel_pkg::cmd_t                        cmd [accel_pkg::ACCEL_COUNT],
  output logic [accel_pkg::ACCEL_COUNT-1:0]      cmd_valid,
  input  logic [accel_pkg::ACCEL_COUNT-1:0]      cmd_ready,
  input  accel_pkg::status_t                     status [accel_pkg::ACCEL_COUNT],

  output logic                                   mem_wr_en,
  output logic [accel_pkg::PMEM_WORD_ADDR_WIDTH-1:0] mem_wr_addr,
  output logic [accel_pkg::IO_STRB_WIDTH-1:0]    mem_wr_strb,
  output logic [accel_pkg::IO_DATA_WIDTH-1:0]    mem_wr_data
);

  import accel_pkg::*;

  logic [ACCEL_COUNT-1:0]     start_pending;
  logic [ACCEL_COUNT-1:0]     done_vec;
  logic [ACCEL_SEL_WIDTH-1:0] sel;
  logic [3:0]                 reg_off;
  logic                       mem_space;
  logic                       glob_space;
  logic                       reg_write;
  logic [IO_DATA_WIDTH-1:0]   rd_mux;

  // ======================================================================
  // Address decode
  // ======================================================================
  assign mem_space  = io_addr[11];
  assign glob_space = io_addr[7];
  assign sel        = io_addr[4 +: ACCEL_SEL_WIDTH];
  assign reg_off    = {io_addr[3:2], 2'b00};
  assign reg_write  = io_en && io_wen && !mem_space && !glob_space;

  // Packet memory writes pass straight to the memory port.
  assign mem_wr_en   = io_en && io_wen && mem_space;
  assign mem_wr_addr = io_addr[PMEM_ADDR_WIDTH-1:2];
  assign mem_wr_strb = io_strb;
  assign mem_wr_data = io_wr_data;

  assign cmd_valid = start_pending;

  always_comb begin
    for (int i = 0; i < ACCEL_COUNT; i++) begin
      done_vec[i] = status[i].done;
    end
  end

  // ======================================================================
  // Command registers
  // ======================================================================
  always_ff @(posedge clk) begin
    if (reg_write) begin
      case (reg_off)
        REG_LEN:     cmd[sel].len     <= io_wr_data[LEN_WIDTH-1:0];
        REG_ADDR:    cmd[sel].addr    <= io_wr_data[PMEM_ADDR_WIDTH-1:0];
        REG_PATTERN: cmd[sel].pattern <= io_wr_data;
        default: ;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      start_pending <= '0;
      io_rd_valid   <= 1'b0;
    end else begin
      start_pending <= start_pending & ~cmd_ready;  // Clear on acceptance.
      if (reg_write && reg_off == REG_CTRL && io_strb[0] && io_wr_data[0]) begin
        start_pending[sel] <= 1'b1;
      end
      io_rd_valid <= io_en && !io_wen;
    end
  end

  // ======================================================================
  // Read path
  // ======================================================================
  always_comb begin
    rd_mux = '0;
    if (mem_space) begin
      rd_mux = '0;  // Packet memory is write only.
    end else if (glob_space) begin
      rd_mux[ACCEL_COUNT-1:0] = done_vec;
    end else begin
      case (reg_off)
        REG_CTRL: begin
          rd_mux[0] = start_pending[sel];
          rd_mux[1] = cmd_ready[sel];
          rd_mux[8] = status[sel].done;
          rd_mux[9] = status[sel].match;
        end
        REG_LEN:     rd_mux[LEN_WIDTH-1:0]       = cmd[sel].len;
        REG_ADDR:    rd_mux[PMEM_ADDR_WIDTH-1:0] = cmd[sel].addr;
        REG_PATTERN: rd_mux                      = cmd[sel].pattern;
        default: ;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (io_en && !io_wen) begin
      io_rd_data <= rd_mux;
    end
  end

endmodule

`default_nettype wire

// File: source/pkt_mem.sv
`default_nettype none

module pkt_mem (
  input  logic                                       clk,

  input  logic                                       wr_en,
  input  logic [accel_pkg::PMEM_WORD_ADDR_WIDTH-1:0] wr_addr,
  input  logic [accel_pkg::IO_STRB_WIDTH-1:0]        wr_strb,
  input  logic [accel_pkg::IO_DATA_WIDTH-1:0]        wr_data,

  input  logic                                       rd_en,
  input  logic [accel_pkg::PMEM_WORD_ADDR_WIDTH-1:0] rd_addr,
  output logic [accel_pkg::IO_DATA_WIDTH-1:0]        rd_data
);

  import accel_pkg::*;

  logic [IO_DATA_WIDTH-1:0] mem [PMEM_WORDS];

  // Byte lanes are written independently.
  always_ff @(posedge clk) begin
    if (wr_en) begin
      for (int b = 0; b < IO_STRB_WIDTH; b++) begin
        if (wr_strb[b]) begin
          mem[wr_addr][8*b +: 8] <= wr_data[8*b +: 8];
        end
      end
    end
  end

  // Registered read, a colliding write is not forwarded.
  always_ff @(posedge clk) begin
    if (rd_en) begin
      rd_data <= mem[rd_addr];
    end
  end

endmodule

`default_nettype wire

// File: source/mem_arbiter.sv
`default_nettype none

module mem_arbiter (
  input  logic                                       clk,
  input  logic                                       rst,

  input  accel_pkg::mem_req_t                        req [accel_pkg::ACCEL_COUNT],
  input  logic [accel_pkg::ACCEL_COUNT-1:0]          req_valid,
  output logic [accel_pkg::ACCEL_COUNT-1:0]          req_ready,
  output accel_pkg::mem_rsp_t                        rsp [accel_pkg::ACCEL_COUNT],

  output logic                                       rd_en,
  output logic [accel_pkg::PMEM_WORD_ADDR_WIDTH-1:0] rd_addr,
  input  logic [accel_pkg::IO_DATA_WIDTH-1:0]        rd_data
);

  import accel_pkg::*;

  logic [ACCEL_SEL_WIDTH-1:0] prio;       // Highest priority requester.
  logic [ACCEL_SEL_WIDTH-1:0] gnt_idx;
  logic                       gnt_any;
  logic [ACCEL_SEL_WIDTH-1:0] owner_q;    // Owner of the read in flight.
  logic [ACCEL_SEL_WIDTH-1:0] rsp_owner;
  logic                       rsp_valid_q;

  // ======================================================================
  // Round-robin pick
  // ======================================================================
  always_comb begin : pick
    logic [ACCEL_SEL_WIDTH-1:0] idx;
    gnt_any   = 1'b0;
    gnt_idx   = '0;
    req_ready = '0;
    for (int i = 0; i < ACCEL_COUNT; i++) begin
      idx = prio + ACCEL_SEL_WIDTH'(i);
      if (!gnt_any && req_valid[idx]) begin
        gnt_any = 1'b1;
        gnt_idx = idx;
      end
    end
    if (gnt_any) begin
      req_ready[gnt_idx] = 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      prio        <= '0;
      rd_en       <= 1'b0;
      rsp_valid_q <= 1'b0;
    end else begin
      if (gnt_any) begin
        prio <= gnt_idx + 1'b1;
      end
      rd_en       <= gnt_any;
      rsp_valid_q <= rd_en;  // Memory read takes one cycle.
    end
  end

  always_ff @(posedge clk) begin
    rd_addr   <= req[gnt_idx].addr;
    owner_q   <= gnt_idx;
    rsp_owner <= owner_q;
  end

  // Data goes to everyone, valid only to the owner.
  always_comb begin
    for (int i = 0; i < ACCEL_COUNT; i++) begin
      rsp[i].valid = rsp_valid_q && (rsp_owner == ACCEL_SEL_WIDTH'(i));
      rsp[i].data  = rd_data;
    end
  end

endmodule

`default_nettype wire

// File: matcher/match_engine.sv
`default_nettype none

module match_engine (
  input  logic                clk,
  input  logic                rst,

  input  accel_pkg::cmd_t     cmd,
  input  logic                cmd_valid,
  output logic                cmd_ready,
  output accel_pkg::status_t  status,

  output accel_pkg::mem_req_t req,
  output logic                req_valid,
  input  logic                req_ready,
  input  accel_pkg::mem_rsp_t rsp
);

  import accel_pkg::*;

  typedef enum logic [1:0] {
    S_IDLE,
    S_FETCH,
    S_WAIT,
    S_SHIFT
  } state_t;

  state_t                     state;
  logic                       done_q;
  logic                       match_q;
  logic [PMEM_ADDR_WIDTH-1:0] byte_addr;  // Next byte to shift in.
  logic [LEN_WIDTH-1:0]       remain;
  logic [31:0]                pattern;
  logic [31:0]                word;
  logic [31:0]                window;
  logic [31:0]                next_window;
  logic [7:0]                 cur_byte;
  logic [1:0]                 fill;       // Bytes shifted, saturates at 3.

  // Only accept when a command is actually offered.
  assign cmd_ready = cmd_valid && (state == S_IDLE);

  assign req_valid = (state == S_FETCH);
  assign req.addr  = byte_addr[PMEM_ADDR_WIDTH-1:2];

  assign status.busy  = (state != S_IDLE);
  assign status.done  = done_q;
  assign status.match = match_q;

  // Newest byte enters at the top, so the oldest ends up in byte 0.
  assign cur_byte    = word[{byte_addr[1:0], 3'b000} +: 8];
  assign next_window = {cur_byte, window[31:8]};

  // ======================================================================
  // Control FSM
  // ======================================================================
  always_ff @(posedge clk) begin
    if (rst) begin
      state   <= S_IDLE;
      done_q  <= 1'b0;
      match_q <= 1'b0;
    end else begin
      case (state)
        S_IDLE: begin
          if (cmd_ready) begin
            match_q <= 1'b0;
            done_q  <= (cmd.len == '0);  // Empty range finishes at once.
            if (cmd.len != '0) begin
              state <= S_FETCH;
            end
          end
        end
        S_FETCH: begin
          if (req_ready) begin
            state <= S_WAIT;
          end
        end
        S_WAIT: begin
          if (rsp.valid) begin
            state <= S_SHIFT;
          end
        end
        S_SHIFT: begin
          if (fill == 2'd3 && next_window == pattern) begin
            match_q <= 1'b1;  // Sticky.
          end
          if (remain == LEN_WIDTH'(1)) begin
            state  <= S_IDLE;
            done_q <= 1'b1;
          end else if (byte_addr[1:0] == 2'd3) begin
            state <= S_FETCH;  // Word used up.
          end
        end
        default: state <= S_IDLE;
      endcase
    end
  end

  // ======================================================================
  // Datapath
  // ======================================================================
  always_ff @(posedge clk) begin
    case (state)
      S_IDLE: begin
        if (cmd_ready) begin
          byte_addr <= cmd.addr;
          remain    <= cmd.len;
          pattern   <= cmd.pattern;
          fill      <= 2'd0;
        end
      end
      S_WAIT: begin
        if (rsp.valid) begin
          word <= rsp.data;
        end
      end
      S_SHIFT: begin
        window    <= next_window;
        byte_addr <= byte_addr + 1'b1;
        remain    <= remain - 1'b1;
        if (fill != 2'd3) begin
          fill <= fill + 1'b1;
        end
      end
      default: ;
    endcase
  end

endmodule

`default_nettype wire

// File: source/accel_top.sv
`default_nettype none

module accel_top (
  input  logic                                clk,
  input  logic                                rst,

  input  logic                                io_en,
  input  logic                                io_wen,
  input  logic [accel_pkg::IO_STRB_WIDTH-1:0] io_strb,
  input  logic [accel_pkg::IO_ADDR_WIDTH-1:0] io_addr,
  input  logic [accel_pkg::IO_DATA_WIDTH-1:0] io_wr_data,
  output logic [accel_pkg::IO_DATA_WIDTH-1:0] io_rd_data,
  output logic                                io_rd_valid
);

  import accel_pkg::*;

  cmd_t                            cmd [ACCEL_COUNT];
  logic [ACCEL_COUNT-1:0]          cmd_valid;
  logic [ACCEL_COUNT-1:0]          cmd_ready;
  status_t                         status [ACCEL_COUNT];

  logic                            mem_wr_en;
  logic [PMEM_WORD_ADDR_WIDTH-1:0] mem_wr_addr;
  logic [IO_STRB_WIDTH-1:0]        mem_wr_strb;
  logic [IO_DATA_WIDTH-1:0]        mem_wr_data;

  mem_req_t                        req [ACCEL_COUNT];
  logic [ACCEL_COUNT-1:0]          req_valid;
  logic [ACCEL_COUNT-1:0]          req_ready;
  mem_rsp_t                        rsp [ACCEL_COUNT];

  logic                            rd_en;
  logic [PMEM_WORD_ADDR_WIDTH-1:0] rd_addr;
  logic [IO_DATA_WIDTH-1:0]        rd_data;

  accel_regs i_regs (
    .clk         (clk),
    .rst         (rst),
    .io_en       (io_en),
    .io_wen      (io_wen),
    .io_strb     (io_strb),
    .io_addr     (io_addr),
    .io_wr_data  (io_wr_data),
    .io_rd_data  (io_rd_data),
    .io_rd_valid (io_rd_valid),
    .cmd         (cmd),
    .cmd_valid   (cmd_valid),
    .cmd_ready   (cmd_ready),
    .status      (status),
    .mem_wr_en   (mem_wr_en),
    .mem_wr_addr (mem_wr_addr),
    .mem_wr_strb (mem_wr_strb),
    .mem_wr_data (mem_wr_data)
  );

  pkt_mem i_mem (
    .clk     (clk),
    .wr_en   (mem_wr_en),
    .wr_addr (mem_wr_addr),
    .wr_strb (mem_wr_strb),
    .wr_data (mem_wr_data),
    .rd_en   (rd_en),
    .rd_addr (rd_addr),
    .rd_data (rd_data)
  );

  mem_arbiter i_arb (
    .clk       (clk),
    .rst       (rst),
    .req       (req),
    .req_valid (req_valid),
    .req_ready (req_ready),
    .rsp       (rsp),
    .rd_en     (rd_en),
    .rd_addr   (rd_addr),
    .rd_data   (rd_data)
  );

  // One engine per command slot.
  for (genvar n = 0; n < ACCEL_COUNT; n++) begin : g_eng
    match_engine i_eng (
      .clk       (clk),
      .rst       (rst),
      .cmd       (cmd[n]),
      .cmd_valid (cmd_valid[n]),
      .cmd_ready (cmd_ready[n]),
      .status    (status[n]),
      .req       (req[n]),
      .req_valid (req_valid[n]),
      .req_ready (req_ready[n]),
      .rsp       (rsp[n])
    );
  end

endmodule

`default_nettype wire

// File: sim/accel_tb_sva.sv
`default_nettype none

module accel_tb_sva (
  input logic                              clk,
  input logic                              rst,
  input logic                              io_en,
  input logic                              io_wen,
  input logic                              io_rd_valid,
  input accel_pkg::mem_req_t               req [accel_pkg::ACCEL_COUNT],
  input logic [accel_pkg::ACCEL_COUNT-1:0] req_valid,
  input logic [accel_pkg::ACCEL_COUNT-1:0] req_ready
);
  timeunit 1ns;
  timeprecision 1ps;

  import accel_pkg::*;

  // A read is answered exactly one cycle after its request.
  a_rd_timing : assert property (@(posedge clk) disable iff (rst)
    io_rd_valid == $past(io_en && !io_wen))
    else $error("io_rd_valid does not follow the read request by one cycle");

  a_one_grant : assert property (@(posedge clk) disable iff (rst) $onehot0(req_ready))
    else $error("arbiter granted more than one request in a cycle");

  for (genvar n = 0; n < ACCEL_COUNT; n++) begin : g_req
    a_req_hold : assert property (@(posedge clk) disable iff (rst)
      req_valid[n] && !req_ready[n] |=> req_valid[n] && $stable(req[n]))
      else $error("engine %0d dropped or changed its request before the grant", n);
  end

endmodule

`default_nettype wire

// File: sim/accel_tb.sv
`default_nettype none

module accel_tb;
  timeunit 1ns;
  timeprecision 1ps;

  import accel_pkg::*;

  logic                     clk = 1'b0;
  logic                     rst;
  logic                     io_en;
  logic                     io_wen;
  logic [IO_STRB_WIDTH-1:0] io_strb;
  logic [IO_ADDR_WIDTH-1:0] io_addr;
  logic [IO_DATA_WIDTH-1:0] io_wr_data;
  logic [IO_DATA_WIDTH-1:0] io_rd_data;
  logic                     io_rd_valid;

  logic [7:0]               mem_model [PMEM_WORDS*4];  // Byte mirror of the packet memory.
  logic [ACCEL_COUNT-1:0]   done_model;
  int                       value_errors;
  int                       timeout_errors;

  accel_top i_accel_top (
    .clk         (clk),
    .rst         (rst),
    .io_en       (io_en),
    .io_wen      (io_wen),
    .io_strb     (io_strb),
    .io_addr     (io_addr),
    .io_wr_data  (io_wr_data),
    .io_rd_data  (io_rd_data),
    .io_rd_valid (io_rd_valid)
  );

  bind accel_top accel_tb_sva i_sva (
    .clk         (clk),
    .rst         (rst),
    .io_en       (io_en),
    .io_wen      (io_wen),
    .io_rd_valid (io_rd_valid),
    .req         (req),
    .req_valid   (req_valid),
    .req_ready   (req_ready)
  );

  always #50 clk = ~clk;

  // ======================================================================
  // Host port access
  // ======================================================================
  function automatic logic [IO_ADDR_WIDTH-1:0] engine_reg_addr(input int n, input logic [3:0] off);
    return IO_ADDR_WIDTH'(n * 16) | IO_ADDR_WIDTH'(off);
  endfunction

  task automatic io_write(input logic [IO_ADDR_WIDTH-1:0] addr, input logic [31:0] data,
                          input logic [3:0] strb);
    @(posedge clk);
    io_en      <= 1'b1;
    io_wen     <= 1'b1;
    io_addr    <= addr;
    io_wr_data <= data;
    io_strb    <= strb;
    @(posedge clk);
    io_en  <= 1'b0;
    io_wen <= 1'b0;
  endtask

  task automatic io_read(input logic [IO_ADDR_WIDTH-1:0] addr, output logic [31:0] data);
    int waited;
    @(posedge clk);
    io_en   <= 1'b1;
    io_wen  <= 1'b0;
    io_addr <= addr;
    @(posedge clk);
    io_en <= 1'b0;
    @(negedge clk);
    waited = 0;
    while (!io_rd_valid && waited < 4) begin
      @(negedge clk);
      waited++;
    end
    if (!io_rd_valid) begin
      $display("Read of address 0x%h got no answer", addr);
      timeout_errors++;
    end else if (waited != 0) begin
      $display("Read of address 0x%h answered %0d cycles late", addr, waited);
      value_errors++;
    end
    data = io_rd_data;
  endtask

  task automatic mem_write(input int word, input logic [31:0] data, input logic [3:0] strb);
    io_write(12'h800 | IO_ADDR_WIDTH'(word * 4), data, strb);
    for (int b = 0; b < 4; b++) begin
      if (strb[b]) mem_model[word*4 + b] = data[8*b +: 8];
    end
  endtask

  // ======================================================================
  // Reference model and compare tasks
  // ======================================================================
  function automatic logic [31:0] model_word_at(input int p);
    return {mem_model[(p + 3) % (PMEM_WORDS*4)], mem_model[(p + 2) % (PMEM_WORDS*4)],
            mem_model[(p + 1) % (PMEM_WORDS*4)], mem_model[p % (PMEM_WORDS*4)]};
  endfunction

  function automatic logic model_match(input int addr, input int len, input logic [31:0] pat);
    logic hit;
    hit = 1'b0;
    for (int i = 0; i + 4 <= len; i++) begin
      if (model_word_at(addr + i) == pat) hit = 1'b1;
    end
    return hit;
  endfunction

  task automatic check_word(input string name, input logic [31:0] exp, input logic [31:0] act);
    if (act !== exp) begin
      $display("FAILED %s: expected 0x%h, got 0x%h", name, exp, act);
      value_errors++;
    end
  endtask

  task automatic check_status(input string name, input status_t exp, input status_t act);
    if (act !== exp) begin
      $display("FAILED %s: expected 0x%h, got 0x%h", name, exp, act);
      value_errors++;
    end
  endtask

  // ======================================================================
  // Engine commands
  // ======================================================================
  task automatic program_cmd(input int n, input int addr, input int len, input logic [31:0] pat);
    io_write(engine_reg_addr(n, REG_LEN), 32'(len), 4'hf);
    io_write(engine_reg_addr(n, REG_ADDR), 32'(addr), 4'hf);
    io_write(engine_reg_addr(n, REG_PATTERN), pat, 4'hf);
  endtask

  task automatic start_search(input int n, input int addr, input int len, input logic [31:0] pat);
    program_cmd(n, addr, len, pat);
    io_write(engine_reg_addr(n, REG_CTRL), 32'h1, 4'h1);
  endtask

  // Done only counts once the pending start has been taken.
  task automatic wait_done(input int n, output status_t st);
    logic [31:0] ctrl;
    int          polls;
    polls = 0;
    io_read(engine_reg_addr(n, REG_CTRL), ctrl);
    while (!(ctrl[8] && !ctrl[0]) && polls < 400) begin
      polls++;
      io_read(engine_reg_addr(n, REG_CTRL), ctrl);
    end
    if (!(ctrl[8] && !ctrl[0])) begin
      $display("Engine %0d never reported done", n);
      timeout_errors++;
    end
    st.busy  = 1'b0;
    st.done  = ctrl[8];
    st.match = ctrl[9];
  endtask

  task automatic verify_search(input int n, input int addr, input int len, input logic [31:0] pat);
    status_t exp;
    status_t act;
    wait_done(n, act);
    exp.busy  = 1'b0;
    exp.done  = 1'b1;
    exp.match = model_match(addr, len, pat);
    check_status($sformatf("status of engine %0d", n), exp, act);
    done_model[n] = 1'b1;
  endtask

  // ======================================================================
  // Test sequence
  // ======================================================================
  initial begin
    logic [31:0] rd;
    logic [31:0] pat;
    logic [31:0] data;
    logic [31:0] expv;
    logic [3:0]  off;
    int          n;
    int          addr;
    int          len;
    int          b_addr;
    int          b_len;
    logic [31:0] b_pat;
    int          eng_addr [ACCEL_COUNT];
    int          eng_len  [ACCEL_COUNT];
    logic [31:0] eng_pat  [ACCEL_COUNT];

    void'($urandom(32'hb68f));
    rst            = 1'b1;
    io_en          = 1'b0;
    io_wen         = 1'b0;
    io_strb        = '0;
    io_addr        = '0;
    io_wr_data     = '0;
    value_errors   = 0;
    timeout_errors = 0;
    done_model     = '0;
    repeat (4) @(posedge clk);
    rst <= 1'b0;

    for (n = 0; n < ACCEL_COUNT; n++) begin
      io_read(engine_reg_addr(n, REG_CTRL), rd);
      check_word($sformatf("io_rd_data ctrl engine %0d after reset", n), 32'h0, rd);
    end
    io_read(12'h080, rd);
    check_word("io_rd_data global done after reset", 32'h0, rd);

    // Register read-back, masked to the field widths.
    repeat (24) begin
      n    = $urandom_range(ACCEL_COUNT - 1);
      data = $urandom;
      expv = '0;
      case ($urandom_range(2))
        0: begin
          off = REG_LEN;
          expv[LEN_WIDTH-1:0] = data[LEN_WIDTH-1:0];
        end
        1: begin
          off = REG_ADDR;
          expv[PMEM_ADDR_WIDTH-1:0] = data[PMEM_ADDR_WIDTH-1:0];
        end
        default: begin
          off  = REG_PATTERN;
          expv = data;
        end
      endcase
      io_write(engine_reg_addr(n, off), data, 4'hf);
      io_read(engine_reg_addr(n, off), rd);
      check_word($sformatf("io_rd_data engine %0d reg %0d", n, off), expv, rd);
    end

    for (int w = 0; w < PMEM_WORDS; w++) mem_write(w, $urandom, 4'hf);
    repeat (40) mem_write($urandom_range(PMEM_WORDS - 1), $urandom, 4'($urandom));

    // Single searches on engine 0.
    repeat (6) begin
      addr = $urandom_range(900);
      len  = $urandom_range(64, 4);
      pat  = $urandom_range(1) ? model_word_at(addr + $urandom_range(len - 4)) : $urandom;
      start_search(0, addr, len, pat);
      verify_search(0, addr, len, pat);
    end

    // Forced match from an unaligned start.
    addr = 4 * $urandom_range(200) + $urandom_range(3, 1);
    len  = $urandom_range(40, 8);
    pat  = model_word_at(addr + $urandom_range(len - 4));
    start_search(0, addr, len, pat);
    verify_search(0, addr, len, pat);
    io_read(12'h080, rd);
    check_word("io_rd_data global done", 32'(done_model), rd);

    // All engines at once on overlapping ranges.
    addr = $urandom_range(800);
    for (n = 0; n < ACCEL_COUNT; n++) begin
      eng_addr[n] = addr + $urandom_range(12);
      eng_len[n]  = (n == 0) ? $urandom_range(3) : $urandom_range(16);
      eng_pat[n]  = (eng_len[n] >= 4 && $urandom_range(1) == 1) ?
                    model_word_at(eng_addr[n] + $urandom_range(eng_len[n] - 4)) : $urandom;
      program_cmd(n, eng_addr[n], eng_len[n], eng_pat[n]);
    end
    for (n = 0; n < ACCEL_COUNT; n++) begin
      io_write(engine_reg_addr(n, REG_CTRL), 32'h1, 4'h1);
    end
    for (n = 0; n < ACCEL_COUNT; n++) begin
      verify_search(n, eng_addr[n], eng_len[n], eng_pat[n]);
    end
    io_read(12'h080, rd);
    check_word("io_rd_data global done", 32'(done_model), rd);

    // Second start while engine 2 is still scanning.
    n    = 2;
    addr = $urandom_range(700);
    len  = $urandom_range(120, 80);
    start_search(n, addr, len, $urandom);
    b_addr = $urandom_range(900);
    b_len  = $urandom_range(40, 4);
    b_pat  = model_word_at(b_addr + $urandom_range(b_len - 4));
    start_search(n, b_addr, b_len, b_pat);
    io_read(engine_reg_addr(n, REG_CTRL), rd);
    check_word("io_rd_data ctrl pending and ready", 32'h1, rd & 32'h3);
    verify_search(n, b_addr, b_len, b_pat);

    $display("Errors: %0d value, %0d timeout", value_errors, timeout_errors);
    if (value_errors + timeout_errors == 0) begin
      $display("*** PASSED ***");
    end else begin
      $display("*** FAILED ***");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: all.f
common/accel_pkg.sv
source/accel_regs.sv
source/pkt_mem.sv
source/mem_arbiter.sv
matcher/match_engine.sv
source/accel_top.sv
sim/accel_tb_sva.sv
sim/accel_tb.sv

// File: run.sh
#!/bin/sh
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert --timescale 1ns/1ps -Wno-fatal \
  -f all.f --top-module accel_tb \
  && ./obj_dir/Vaccel_tb | tee /dev/stderr | grep -F '*** PASSED ***' > /dev/null \
  && echo "Simulation passed" \
  || { echo "Simulation failed"; exit 1; }
